/* hw/dma_bus_settings.svh */
// Build-time sizes for the DMA bus fabric
// Include wherever a width, depth or master count is needed

`ifndef DMA_BUS_SETTINGS_SVH
`define DMA_BUS_SETTINGS_SVH

// Word address and data widths
`define DMA_ADR_W 16
`define DMA_DAT_W 32

// Transfer length in words
`define DMA_LEN_W 8

// Copy channels, plus one host on the top index
`define DMA_NUM_CHAN    4
`define DMA_NUM_MASTERS 5

// SRAM depth in words; anything at or above draws err
`define SRAM_WORDS 256

`endif

/* hw/dma_bus_pkg.sv */
// Shared types for the DMA bus fabric
// Modules pull these in with a wildcard import in their header

`include "dma_bus_settings.svh"

package dma_bus_pkg;

   // Word address and data word
   typedef logic [`DMA_ADR_W-1:0] wb_adr_t;
   typedef logic [`DMA_DAT_W-1:0] wb_dat_t;

   // One-hot bus owner, one bit per master
   typedef logic [`DMA_NUM_MASTERS-1:0] grant_t;

   // Copy request for a single channel
   typedef struct packed {
      wb_adr_t src;                    // First source word
      wb_adr_t dst;                    // First destination word
      logic [`DMA_LEN_W-1:0] len;      // Words to copy
   } chan_cmd_t;

endpackage

/* hw/wb_if.sv */
// Wishbone-style bus bundle used between the masters, mixer and SRAM
// Master drives the request side, slave drives ack, err and read data

`timescale 1ns/10ps

interface wb_if import dma_bus_pkg::*; ();

   // Request
   logic    cyc;
   logic    stb;
   logic    we;
   wb_adr_t adr;
   wb_dat_t dat_w;

   // Response
   wb_dat_t dat_r;
   logic    ack;
   logic    err;

   modport master (
      output cyc, stb, we, adr, dat_w,
      input  dat_r, ack, err
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack, err
   );

endinterface

/* hw/bus_arbiter.sv */
// Round-robin bus arbiter with a registered one-hot grant
// Owner keeps the bus while its request stays high; a free bus goes to
// the next requester after the previous owner, one clock later

`timescale 1ns/10ps
`include "dma_bus_settings.svh"

module bus_arbiter import dma_bus_pkg::*; (
   input  logic                        wb_clk_i,
   input  logic                        reset_i,
   input  logic [`DMA_NUM_MASTERS-1:0] req_i,
   output grant_t                      gnt_o
);

   localparam int NM    = `DMA_NUM_MASTERS;
   localparam int PTR_W = $clog2(NM);

   grant_t             gnt_q;
   grant_t             next_gnt;
   logic [PTR_W-1:0]   last_q;
   logic [PTR_W-1:0]   next_idx;
   logic               found;
   logic               hold;

   assign hold  = |(gnt_q & req_i);    // Owner still has cyc up
   assign gnt_o = gnt_q;

   // Search starts one past the last owner and wraps
   always_comb begin
      int idx;
      next_gnt = '0;
      next_idx = last_q;
      found    = 1'b0;
      for (int k = 1; k <= NM; k++) begin
         idx = (int'(last_q) + k) % NM;
         if (!found && req_i[idx]) begin
            next_gnt[idx] = 1'b1;
            next_idx      = PTR_W'(idx);
            found         = 1'b1;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         gnt_q  <= '0;
         last_q <= PTR_W'(NM - 1);     // Master 0 wins first
      end else if (!hold) begin
         gnt_q <= next_gnt;            // Empty when nobody asks
         if (found)
            last_q <= next_idx;
      end
   end

endmodule

/* hw/bus_mixer.sv */
// Shared-bus mixer for the DMA fabric
// Puts the granted master's request on the single slave bus and sends
// ack, err and read data back to that master alone. Arbitration is done
// by the embedded round-robin arbiter, fed from every master's cyc

`timescale 1ns/10ps
`include "dma_bus_settings.svh"

module bus_mixer import dma_bus_pkg::*; (
   input  logic wb_clk_i,
   input  logic reset_i,
   wb_if.slave  m_bus [`DMA_NUM_MASTERS],
   wb_if.master s_bus
);

   localparam int NM = `DMA_NUM_MASTERS;

   grant_t        gnt;
   logic [NM-1:0] cyc_v;
   logic [NM-1:0] stb_v;
   logic [NM-1:0] we_v;
   wb_adr_t       adr_v [NM];
   wb_dat_t       dat_v [NM];

   for (genvar i = 0; i < NM; i++) begin : g_master
      // Flatten the requests
      assign cyc_v[i] = m_bus[i].cyc;
      assign stb_v[i] = m_bus[i].stb;
      assign we_v[i]  = m_bus[i].we;
      assign adr_v[i] = m_bus[i].adr;
      assign dat_v[i] = m_bus[i].dat_w;

      // Only the owner hears the slave
      assign m_bus[i].ack   = s_bus.ack & gnt[i];
      assign m_bus[i].err   = s_bus.err & gnt[i];
      assign m_bus[i].dat_r = gnt[i] ? s_bus.dat_r : '0;
   end

   bus_arbiter u_arb (
      .wb_clk_i (wb_clk_i),
      .reset_i  (reset_i),
      .req_i    (cyc_v),
      .gnt_o    (gnt)
   );

   // One-hot and-or select, all zero with no grant
   always_comb begin
      s_bus.cyc   = |(gnt & cyc_v);
      s_bus.stb   = |(gnt & stb_v);
      s_bus.we    = |(gnt & we_v);
      s_bus.adr   = '0;
      s_bus.dat_w = '0;
      for (int i = 0; i < NM; i++) begin
         s_bus.adr   = s_bus.adr   | (adr_v[i] & {`DMA_ADR_W{gnt[i]}});
         s_bus.dat_w = s_bus.dat_w | (dat_v[i] & {`DMA_DAT_W{gnt[i]}});
      end
   end

endmodule

/* hw/dma_channel.sv */
// Single DMA copy engine
// A start strobe latches src, dst and len; each word is a bus read from
// src and a write of the same data to dst inside one cyc tenure, with cyc
// dropped for one cycle between words. done_o or err_o pulses at the end

`timescale 1ns/10ps
`include "dma_bus_settings.svh"

module dma_channel import dma_bus_pkg::*; (
   input  logic      wb_clk_i,
   input  logic      reset_i,
   input  logic      start_i,
   input  chan_cmd_t cmd_i,
   output logic      done_o,
   output logic      err_o,
   wb_if.master      bus
);

   localparam int LEN_W = `DMA_LEN_W;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WRITE,
      ST_GAP
   } state_t;

   state_t            state_q;
   wb_adr_t           src_q;
   wb_adr_t           dst_q;
   logic [LEN_W-1:0]  cnt_q;          // Words still to move
   wb_dat_t           data_q;
   logic              busy;
   logic              last_word;

   assign busy      = (state_q == ST_READ) || (state_q == ST_WRITE);
   assign last_word = (cnt_q == LEN_W'(1));

   // Request side of the bus
   assign bus.cyc   = busy;
   assign bus.stb   = busy;
   assign bus.we    = (state_q == ST_WRITE);
   assign bus.adr   = (state_q == ST_WRITE) ? dst_q : src_q;
   assign bus.dat_w = data_q;

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
         done_o  <= 1'b0;
         err_o   <= 1'b0;
      end else begin
         done_o <= 1'b0;
         err_o  <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (start_i) begin
                  if (cmd_i.len == '0)
                     done_o <= 1'b1;   // Nothing to copy
                  else
                     state_q <= ST_READ;
               end
            end
            ST_READ: begin
               if (bus.err) begin
                  err_o   <= 1'b1;
                  state_q <= ST_IDLE;
               end else if (bus.ack) begin
                  state_q <= ST_WRITE;
               end
            end
            ST_WRITE: begin
               if (bus.err) begin
                  err_o   <= 1'b1;
                  state_q <= ST_IDLE;
               end else if (bus.ack) begin
                  if (last_word) begin
                     done_o  <= 1'b1;
                     state_q <= ST_IDLE;
                  end else begin
                     state_q <= ST_GAP;  // Let the others in
                  end
               end
            end
            default: state_q <= ST_READ;  // Gap lasts one cycle
         endcase
      end
   end

   // Addresses, count and data word
   always_ff @(posedge wb_clk_i) begin
      if (state_q == ST_IDLE && start_i) begin
         src_q <= cmd_i.src;
         dst_q <= cmd_i.dst;
         cnt_q <= cmd_i.len;
      end
      if (state_q == ST_READ && bus.ack)
         data_q <= bus.dat_r;
      if (state_q == ST_WRITE && bus.ack) begin
         src_q <= src_q + wb_adr_t'(1);
         dst_q <= dst_q + wb_adr_t'(1);
         cnt_q <= cnt_q - LEN_W'(1);
      end
   end

endmodule

/* hw/wb_sram.sv */
// Word-addressed on-chip SRAM on the shared bus
// Answers one cycle after cyc and stb, with ack in range and err beyond
// SRAM_WORDS. Read data comes with ack; writes store full words on ack

`timescale 1ns/10ps
`include "dma_bus_settings.svh"

module wb_sram import dma_bus_pkg::*; (
   input  logic wb_clk_i,
   input  logic reset_i,
   wb_if.slave  bus
);

   localparam int IDX_W = $clog2(`SRAM_WORDS);

   wb_dat_t          mem [`SRAM_WORDS];
   wb_dat_t          dat_q;
   logic             ack_q;
   logic             err_q;
   logic             req;
   logic             in_range;
   logic [IDX_W-1:0] idx;

   // A held stb gets no second answer
   assign req      = bus.cyc & bus.stb & ~ack_q & ~err_q;
   assign in_range = (bus.adr < wb_adr_t'(`SRAM_WORDS));
   assign idx      = bus.adr[IDX_W-1:0];

   assign bus.ack   = ack_q;
   assign bus.err   = err_q;
   assign bus.dat_r = dat_q;

   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req & in_range;
         err_q <= req & ~in_range;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (req && in_range) begin
         if (bus.we)
            mem[idx] <= bus.dat_w;
         else
            dat_q <= mem[idx];       // Shows up with ack
      end
   end

endmodule

/* hw/dma_bus_top.sv */
// Top level of the DMA bus fabric
// Four copy channels and an external host share one bus into the SRAM.
// Host and channel commands are plain ports; the host sits on the
// highest master index

`timescale 1ns/10ps
`include "dma_bus_settings.svh"

module dma_bus_top import dma_bus_pkg::*; (
   input  logic                     wb_clk_i,
   input  logic                     reset_i,

   // Host port
   input  logic                     host_cyc_i,
   input  logic                     host_stb_i,
   input  logic                     host_we_i,
   input  wb_adr_t                  host_adr_i,
   input  wb_dat_t                  host_dat_i,
   output wb_dat_t                  host_dat_o,
   output logic                     host_ack_o,
   output logic                     host_err_o,

   // Channel commands and status
   input  logic [`DMA_NUM_CHAN-1:0] chan_start_i,
   input  wb_adr_t                  chan_src_i [`DMA_NUM_CHAN],
   input  wb_adr_t                  chan_dst_i [`DMA_NUM_CHAN],
   input  logic [`DMA_LEN_W-1:0]    chan_len_i [`DMA_NUM_CHAN],
   output logic [`DMA_NUM_CHAN-1:0] chan_done_o,
   output logic [`DMA_NUM_CHAN-1:0] chan_err_o
);

   localparam int HOST = `DMA_NUM_CHAN;

   wb_if m_if [`DMA_NUM_MASTERS] ();
   wb_if s_if ();

   for (genvar i = 0; i < `DMA_NUM_CHAN; i++) begin : g_chan
      chan_cmd_t cmd;

      assign cmd = '{src: chan_src_i[i], dst: chan_dst_i[i], len: chan_len_i[i]};

      dma_channel u_chan (
         .wb_clk_i (wb_clk_i),
         .reset_i  (reset_i),
         .start_i  (chan_start_i[i]),
         .cmd_i    (cmd),
         .done_o   (chan_done_o[i]),
         .err_o    (chan_err_o[i]),
         .bus      (m_if[i])
      );
   end

   // Host straight onto its master slot
   assign m_if[HOST].cyc   = host_cyc_i;
   assign m_if[HOST].stb   = host_stb_i;
   assign m_if[HOST].we    = host_we_i;
   assign m_if[HOST].adr   = host_adr_i;
   assign m_if[HOST].dat_w = host_dat_i;
   assign host_dat_o       = m_if[HOST].dat_r;
   assign host_ack_o       = m_if[HOST].ack;
   assign host_err_o       = m_if[HOST].err;

   bus_mixer u_mixer (
      .wb_clk_i (wb_clk_i),
      .reset_i  (reset_i),
      .m_bus    (m_if),
      .s_bus    (s_if)
   );

   wb_sram u_sram (
      .wb_clk_i (wb_clk_i),
      .reset_i  (reset_i),
      .bus      (s_if)
   );

endmodule

/* verif/tb_clock_gen.sv */
// Clock and reset source for the DMA bus testbench
// 4 ns clock, reset held high for the first 10 rising edges

`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   initial begin
      reset_o = 1'b1;
      repeat (10) @(posedge clk_o);
      #1 reset_o = 1'b0;               // Released off the edge, like all stimulus
   end

endmodule

/* verif/dma_bus_tb.sv */
// Testbench for the DMA bus fabric
// Drives the host port and the four copy channels with seeded random
// stimulus and checks every host read against a shadow memory model.
// Prints one line per test and a closing line with the counts

`timescale 1ns/10ps
`include "dma_bus_settings.svh"

module dma_bus_tb import dma_bus_pkg::*; ();

   localparam int NC          = `DMA_NUM_CHAN;
   localparam int DEPTH       = `SRAM_WORDS;
   localparam int HOST_WAIT   = 200;
   // Words moved or accessed by host test, single copy, contention, error path
   localparam int TOTAL_WORDS = (DEPTH + 128) + 52 + 144 + 26;
   localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS + 1000;

   typedef logic [`DMA_LEN_W-1:0] len_t;

   logic          wb_clk;
   logic          reset;
   logic          host_cyc;
   logic          host_stb;
   logic          host_we;
   wb_adr_t       host_adr;
   wb_dat_t       host_dat_w;
   wb_dat_t       host_dat_r;
   logic          host_ack;
   logic          host_err;
   logic [NC-1:0] chan_start;
   wb_adr_t       chan_src [NC];
   wb_adr_t       chan_dst [NC];
   len_t          chan_len [NC];
   logic [NC-1:0] chan_done;
   logic [NC-1:0] chan_err;

   wb_dat_t model [DEPTH];             // Shadow of the SRAM
   int      seed;
   int      cycles;
   int      test_errors;
   int      errors;
   int      tests_run;
   int      tests_bad;
   int      done_cnt [NC];
   int      fail_cnt [NC];

   tb_clock_gen u_clk (
      .clk_o   (wb_clk),
      .reset_o (reset)
   );

   dma_bus_top DUT (
      .wb_clk_i     (wb_clk),
      .reset_i      (reset),
      .host_cyc_i   (host_cyc),
      .host_stb_i   (host_stb),
      .host_we_i    (host_we),
      .host_adr_i   (host_adr),
      .host_dat_i   (host_dat_w),
      .host_dat_o   (host_dat_r),
      .host_ack_o   (host_ack),
      .host_err_o   (host_err),
      .chan_start_i (chan_start),
      .chan_src_i   (chan_src),
      .chan_dst_i   (chan_dst),
      .chan_len_i   (chan_len),
      .chan_done_o  (chan_done),
      .chan_err_o   (chan_err)
   );

   // Status pulses counted mid-cycle
   always @(negedge wb_clk) begin
      for (int i = 0; i < NC; i++) begin
         if (chan_done[i] === 1'b1)
            done_cnt[i]++;
         if (chan_err[i] === 1'b1)
            fail_cnt[i]++;
      end
   end

   always @(posedge wb_clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
         $display("tests failed");
         $finish;
      end
   end

   // One host transfer, request held until ack or err
   task automatic host_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                              output wb_dat_t rdat, output logic ack, output logic err);
      int waited;
      @(posedge wb_clk);
      #1;
      host_cyc   = 1'b1;
      host_stb   = 1'b1;
      host_we    = we;
      host_adr   = adr;
      host_dat_w = wdat;
      ack        = 1'b0;
      err        = 1'b0;
      rdat       = '0;
      waited     = 0;
      while (!ack && !err && waited < HOST_WAIT) begin
         @(posedge wb_clk);
         #1;
         ack  = host_ack;
         err  = host_err;
         rdat = host_dat_r;
         waited++;
      end
      host_cyc = 1'b0;
      host_stb = 1'b0;
      host_we  = 1'b0;
      if (!ack && !err) begin
         $display("Host access to %0h got neither ack nor err within %0d cycles",
                  adr, HOST_WAIT);
         test_errors++;
      end
   endtask

   task automatic host_write(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t rdat;
      logic    ack;
      logic    err;
      host_access(1'b1, adr, dat, rdat, ack, err);
      if (ack || err) begin
         assert (ack && !err) else begin
            $display("[ERROR] %0t: write to %0h answered with err", $time, adr);
            test_errors++;
         end
      end
      if (ack)
         model[int'(adr)] = dat;
   endtask

   task automatic host_check(input wb_adr_t adr);
      wb_dat_t rdat;
      logic    ack;
      logic    err;
      host_access(1'b0, adr, '0, rdat, ack, err);
      if (ack || err) begin
         assert (ack && rdat == model[int'(adr)]) else begin
            $display("[ERROR] %0t: read of %0h gave %h (err %b), expected %h",
                     $time, adr, rdat, err, model[int'(adr)]);
            test_errors++;
         end
      end
   endtask

   task automatic check_region(input int base, input int len);
      for (int i = 0; i < len; i++)
         host_check(wb_adr_t'(base + i));
   endtask

   // Word-by-word copy in the model
   task automatic model_copy(input int src, input int dst, input int len);
      for (int i = 0; i < len; i++)
         model[dst + i] = model[src + i];
   endtask

   task automatic set_command(input int ch, input int src, input int dst, input int len);
      chan_src[ch] = wb_adr_t'(src);
      chan_dst[ch] = wb_adr_t'(dst);
      chan_len[ch] = len_t'(len);
   endtask

   task automatic launch(input logic [NC-1:0] mask);
      @(posedge wb_clk);
      #1;
      chan_start = mask;
      @(posedge wb_clk);
      #1;
      chan_start = '0;                 // One-cycle strobe
   endtask

   // Wait for done or err, then check which one came
   task automatic wait_end(input int ch, input int done0, input int err0,
                           input logic want_done, input int limit);
      int waited;
      waited = 0;
      while (done_cnt[ch] == done0 && fail_cnt[ch] == err0 && waited < limit) begin
         @(posedge wb_clk);
         #1;
         waited++;
      end
      if (done_cnt[ch] == done0 && fail_cnt[ch] == err0) begin
         $display("Channel %0d gave neither done nor err within %0d cycles", ch, limit);
         test_errors++;
      end else begin
         assert (want_done ? (done_cnt[ch] == done0 + 1 && fail_cnt[ch] == err0)
                           : (fail_cnt[ch] == err0 + 1 && done_cnt[ch] == done0)) else begin
            $display("[ERROR] %0t: channel %0d ended with %0d done and %0d err pulses",
                     $time, ch, done_cnt[ch] - done0, fail_cnt[ch] - err0);
            test_errors++;
         end
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("%0t  %s: ok", $time, name);
      end else begin
         tests_bad++;
         $display("%0t  %s: FAIL with %0d errors", $time, name, test_errors);
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   initial begin
      wb_adr_t       addrs [64];
      wb_dat_t       rd;
      logic          ack;
      logic          err;
      logic [NC-1:0] mask;
      int            r;
      int            k;
      int            len [NC];
      int            done0 [NC];
      int            err0 [NC];

      seed        = 12219;
      cycles      = 0;
      test_errors = 0;
      errors      = 0;
      tests_run   = 0;
      tests_bad   = 0;
      host_cyc    = 1'b0;
      host_stb    = 1'b0;
      host_we     = 1'b0;
      host_adr    = '0;
      host_dat_w  = '0;
      chan_start  = '0;
      for (int c = 0; c < NC; c++) begin
         set_command(c, 0, 0, 0);
         done_cnt[c] = 0;
         fail_cnt[c] = 0;
      end

      // 10 cycles in reset, 3 after
      repeat (13) begin
         @(posedge wb_clk);
         #1;
         assert (host_ack === 1'b0 && host_err === 1'b0 &&
                 chan_done === '0 && chan_err === '0) else begin
            $display("[ERROR] %0t: outputs not idle around reset", $time);
            test_errors++;
         end
      end
      finish_test("reset state");

      // Whole SRAM gets a known pattern first
      for (int a = 0; a < DEPTH; a++)
         host_write(wb_adr_t'(a), {~wb_adr_t'(a), wb_adr_t'(a)} ^ 32'h3C96_A55A);
      for (int i = 0; i < 64; i++) begin
         r        = $random(seed);
         addrs[i] = wb_adr_t'(r & (DEPTH - 1));
         host_write(addrs[i], $random(seed));
      end
      for (int i = 0; i < 64; i++)
         host_check(addrs[i]);
      finish_test("host access");

      r      = $random(seed);
      k      = r & (NC - 1);
      len[0] = 1 + ((r >> 4) & 15);
      set_command(k, 40, 180, len[0]);
      done0[k] = done_cnt[k];
      err0[k]  = fail_cnt[k];
      mask     = '0;
      mask[k]  = 1'b1;
      launch(mask);
      wait_end(k, done0[k], err0[k], 1'b1, 40 * len[0] + 100);
      model_copy(40, 180, len[0]);
      check_region(180, len[0]);
      check_region(40, len[0]);        // Source untouched
      k = (k + 1) % NC;                // Zero length on the next channel
      set_command(k, 8, 220, 0);
      done0[k] = done_cnt[k];
      err0[k]  = fail_cnt[k];
      mask     = '0;
      mask[k]  = 1'b1;
      launch(mask);
      wait_end(k, done0[k], err0[k], 1'b1, 4);
      check_region(220, 4);
      finish_test("single-channel copy");

      // Disjoint regions below 128, host reads above
      for (int c = 0; c < NC; c++) begin
         len[c] = 1 + ($random(seed) & 15);
         set_command(c, c * 32, c * 32 + 16, len[c]);
         done0[c] = done_cnt[c];
         err0[c]  = fail_cnt[c];
      end
      launch('1);
      for (int i = 0; i < 16; i++) begin
         r = $random(seed);
         host_check(wb_adr_t'(128 + (r & 127)));
      end
      for (int c = 0; c < NC; c++)
         wait_end(c, done0[c], err0[c], 1'b1, 40 * len[c] + 200);
      repeat (20) @(posedge wb_clk);
      #1;
      for (int c = 0; c < NC; c++) begin
         assert (done_cnt[c] == done0[c] + 1) else begin
            $display("[ERROR] %0t: channel %0d pulsed done %0d times",
                     $time, c, done_cnt[c] - done0[c]);
            test_errors++;
         end
         model_copy(c * 32, c * 32 + 16, len[c]);
         check_region(c * 32 + 16, len[c]);
      end
      finish_test("contention");

      for (int i = 0; i < 2; i++) begin
         r = $random(seed);
         host_access(i == 0, wb_adr_t'(DEPTH + (r & 1023)), wb_dat_t'(r), rd, ack, err);
         assert (err && !ack) else begin
            $display("[ERROR] %0t: host access above the SRAM gave ack %b err %b",
                     $time, ack, err);
            test_errors++;
         end
      end
      r = $random(seed);
      k = 1 + ((r >> 8) & 7);           // Good words before the edge
      set_command(2, DEPTH - k, 100, k + 4);
      done0[2] = done_cnt[2];
      err0[2]  = fail_cnt[2];
      launch(4'b0100);
      wait_end(2, done0[2], err0[2], 1'b0, 40 * (k + 4) + 100);
      model_copy(DEPTH - k, 100, k);
      check_region(100, k + 4);
      finish_test("error path");

      $display("Tests run: %0d, passing: %0d, failing: %0d, errors: %0d",
               tests_run, tests_run - tests_bad, tests_bad, errors);
      if (tests_bad == 0 && errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* dma_bus_top.f */
+incdir+hw
hw/dma_bus_pkg.sv
hw/wb_if.sv
hw/bus_arbiter.sv
hw/bus_mixer.sv
hw/dma_channel.sv
hw/wb_sram.sv
hw/dma_bus_top.sv
verif/tb_clock_gen.sv
verif/dma_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the DMA bus testbench with Verilator and run it.
# Exit status is zero only when the log holds the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module dma_bus_tb \
   -f dma_bus_top.f \
   --Mdir obj_dir -o dma_bus_sim

./obj_dir/dma_bus_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
   echo "Simulation PASS"
   exit 0
fi
echo "Simulation FAIL"
exit 1
